/* files.f */
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/decodeUnit.sv
hdl/registerFile.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/writebackStage.sv
hdl/mipsCore.sv
test/tbCore.sv

/* hdl/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit (
	input logic Clk,
	input logic reset,
	input mipsPkg::word idInstr,
	input mipsPkg::word idPcPlus4,
	input mipsPkg::word rsData,
	input mipsPkg::word rtData,
	output mipsPkg::regAddr rsAddr,
	output mipsPkg::regAddr rtAddr,
	input logic stall,
	input logic branchTaken,
	output logic jumpTaken,
	output mipsPkg::word jumpTarget,
	output mipsPkg::idExData exData
);
	import mipsPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	ctrlBits ctrl;
	logic signExt;
	logic useRd;
	regAddr dest;
	word immExt;
	idExData next;

	assign opcode = idInstr[31:26];
	assign funct = idInstr[5:0];
	assign rsAddr = idInstr[25:21];
	assign rtAddr = idInstr[20:16];

	always_comb begin
		ctrl = '0;
		signExt = 1'b1;
		useRd = 1'b0;
		jumpTaken = 1'b0;
		case (opcode)
			opRType: begin
				useRd = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAdd, fnAddu: ctrl.alu = aluAdd;
					fnSub, fnSubu: ctrl.alu = aluSub;
					fnAnd: ctrl.alu = aluAnd;
					fnOr: ctrl.alu = aluOr;
					fnXor: ctrl.alu = aluXor;
					fnNor: ctrl.alu = aluNor;
					fnSlt: ctrl.alu = aluSlt;
					fnSll: begin
						ctrl.alu = aluSll;
						ctrl.aUseShamt = 1'b1;
					end
					default: ctrl.regWrite = 1'b0; // Unknown funct is a no-op
				endcase
			end
			opAddi, opAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.bSrcImm = 1'b1;
				ctrl.alu = aluAdd;
			end
			opSlti: begin
				ctrl.regWrite = 1'b1;
				ctrl.bSrcImm = 1'b1;
				ctrl.alu = aluSlt;
			end
			opAndi, opOri, opXori: begin
				signExt = 1'b0; // Logical immediates zero-extend
				ctrl.regWrite = 1'b1;
				ctrl.bSrcImm = 1'b1;
				ctrl.alu = (opcode == opAndi) ? aluAnd : (opcode == opOri) ? aluOr : aluXor;
			end
			opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.bSrcImm = 1'b1;
				ctrl.alu = aluLui;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.bSrcImm = 1'b1;
				ctrl.alu = aluAdd;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.bSrcImm = 1'b1;
				ctrl.alu = aluAdd;
			end
			opBeq: ctrl.branchEq = 1'b1;
			opBne: ctrl.branchNe = 1'b1;
			opJ: jumpTaken = 1'b1;
			default: ;
		endcase
		dest = useRd ? idInstr[15:11] : idInstr[20:16];
		if (dest == zeroReg)
			ctrl.regWrite = 1'b0;
	end

	assign immExt = signExt ? {{16{idInstr[15]}}, idInstr[15:0]} : {16'h0000, idInstr[15:0]};
	assign jumpTarget = {idPcPlus4[31:28], idInstr[25:0], 2'b00};

	always_comb begin
		next.ctrl = ctrl;
		next.rsVal = rsData;
		next.rtVal = rtData;
		next.rs = rsAddr;
		next.rt = rtAddr;
		next.imm = immExt;
		next.shamt = idInstr[10:6];
		next.dest = dest;
		next.pcPlus4 = idPcPlus4;
	end

	always_ff @(posedge Clk) begin
		exData <= next;
		if (reset || stall || branchTaken)
			exData.ctrl <= '0; // Bubble
	end

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input logic Clk,
	input logic reset,
	input mipsPkg::idExData exData,
	input mipsPkg::fwdSel fwdA,
	input mipsPkg::fwdSel fwdB,
	input mipsPkg::word wbValue,
	output logic branchTaken,
	output mipsPkg::word branchTarget,
	output mipsPkg::exMemData memData
);
	import mipsPkg::*;

	word rsFwd;
	word rtFwd;
	word opA;
	word opB;
	word aluResult;
	exMemData next;

	function automatic word forwardMux(fwdSel sel, word regVal);
		case (sel)
			fromMem: return memData.aluResult;
			fromWb: return wbValue;
			default: return regVal;
		endcase
	endfunction

	always_comb begin
		rsFwd = forwardMux(fwdA, exData.rsVal);
		rtFwd = forwardMux(fwdB, exData.rtVal);
	end

	// Three-way operand choice
	assign opA = exData.ctrl.aUseShamt ? rtFwd : rsFwd;
	assign opB = exData.ctrl.aUseShamt ? {27'd0, exData.shamt} :
		exData.ctrl.bSrcImm ? exData.imm : rtFwd;

	always_comb begin
		case (exData.ctrl.alu)
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluXor: aluResult = opA ^ opB;
			aluNor: aluResult = ~(opA | opB);
			aluSlt: aluResult = {31'd0, $signed(opA) < $signed(opB)};
			aluSll: aluResult = opA << opB[4:0];
			aluLui: aluResult = {opB[15:0], 16'h0000};
			default: aluResult = '0;
		endcase
	end

	assign branchTaken = (exData.ctrl.branchEq && rsFwd == rtFwd) ||
		(exData.ctrl.branchNe && rsFwd != rtFwd);
	assign branchTarget = exData.pcPlus4 + {exData.imm[29:0], 2'b00};

	always_comb begin
		next.regWrite = exData.ctrl.regWrite;
		next.memRead = exData.ctrl.memRead;
		next.memWrite = exData.ctrl.memWrite;
		next.memToReg = exData.ctrl.memToReg;
		next.aluResult = aluResult;
		next.storeData = rtFwd; // SW stores rt
		next.dest = exData.dest;
	end

	always_ff @(posedge Clk) begin
		memData <= next;
		if (reset) begin
			memData.regWrite <= 1'b0;
			memData.memRead <= 1'b0;
			memData.memWrite <= 1'b0;
		end
	end

endmodule

/* hdl/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage #(
	parameter mipsPkg::word resetVector = 32'h0000_0000
) (
	input logic Clk,
	input logic reset,
	input logic stall,
	input logic branchTaken,
	input logic jumpTaken,
	input mipsPkg::word branchTarget,
	input mipsPkg::word jumpTarget,
	input mipsPkg::word instr,
	output mipsPkg::word pc,
	output mipsPkg::word idInstr,
	output mipsPkg::word idPcPlus4
);
	import mipsPkg::*;

	word pcPlus4;
	word pcNext;

	assign pcPlus4 = pc + 32'd4;

	// Branch from EX beats jump from ID
	always_comb begin
		if (branchTaken)
			pcNext = branchTarget;
		else if (jumpTaken)
			pcNext = jumpTarget;
		else if (stall)
			pcNext = pc;
		else
			pcNext = pcPlus4;
	end

	always_ff @(posedge Clk) begin
		if (reset)
			pc <= resetVector;
		else
			pc <= pcNext;
	end

	always_ff @(posedge Clk) begin
		if (reset || branchTaken || jumpTaken) begin
			idInstr <= '0; // Flush to no-op
		end else if (!stall) begin
			idInstr <= instr;
		end
		if (!stall)
			idPcPlus4 <= pcPlus4;
	end

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
	input mipsPkg::regAddr idRs,
	input mipsPkg::regAddr idRt,
	input mipsPkg::idExData exData,
	input mipsPkg::exMemData memData,
	input logic wbWrite,
	input mipsPkg::regAddr wbAddr,
	output logic stall,
	output mipsPkg::fwdSel fwdA,
	output mipsPkg::fwdSel fwdB
);
	import mipsPkg::*;

	// Youngest producer wins
	function automatic fwdSel pickSource(regAddr src);
		if (memData.regWrite && memData.dest != zeroReg && memData.dest == src)
			return fromMem;
		else if (wbWrite && wbAddr != zeroReg && wbAddr == src)
			return fromWb;
		else
			return fromReg;
	endfunction

	always_comb begin
		fwdA = pickSource(exData.rs);
		fwdB = pickSource(exData.rt);
	end

	// Load in EX feeding the instruction in ID
	always_comb begin
		stall = 1'b0;
		if (exData.ctrl.memRead && exData.dest != zeroReg) begin
			if (exData.dest == idRs || exData.dest == idRt)
				stall = 1'b1;
		end
	end

endmodule

/* hdl/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore #(
	parameter mipsPkg::word resetVector = 32'h0000_0000
) (
	input logic Clk,
	input logic reset,
	output mipsPkg::word instrAddr,
	input mipsPkg::word instr,
	output mipsPkg::word dataAddr,
	output mipsPkg::word dataWriteData,
	output logic dataWriteEnable,
	output logic dataReadEnable,
	input mipsPkg::word dataReadData
);
	import mipsPkg::*;

	word idInstr, idPcPlus4;
	word rsData, rtData;
	regAddr rsAddr, rtAddr;
	logic stall;
	logic branchTaken, jumpTaken;
	word branchTarget, jumpTarget;
	fwdSel fwdA, fwdB;
	idExData exData;
	exMemData memData;
	logic wbWrite;
	regAddr wbAddr;
	word wbValue;

	fetchStage #(.resetVector(resetVector)) fetchStage_i (
		.Clk(Clk), .reset(reset), .stall(stall),
		.branchTaken(branchTaken), .jumpTaken(jumpTaken),
		.branchTarget(branchTarget), .jumpTarget(jumpTarget),
		.instr(instr), .pc(instrAddr),
		.idInstr(idInstr), .idPcPlus4(idPcPlus4)
	);

	decodeUnit decodeUnit_i (
		.Clk(Clk), .reset(reset), .idInstr(idInstr), .idPcPlus4(idPcPlus4),
		.rsData(rsData), .rtData(rtData), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.stall(stall), .branchTaken(branchTaken),
		.jumpTaken(jumpTaken), .jumpTarget(jumpTarget), .exData(exData)
	);

	registerFile registerFile_i (
		.Clk(Clk), .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
		.writeEnable(wbWrite), .writeAddr(wbAddr), .writeData(wbValue)
	);

	hazardUnit hazardUnit_i (
		.idRs(rsAddr), .idRt(rtAddr), .exData(exData), .memData(memData),
		.wbWrite(wbWrite), .wbAddr(wbAddr), .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
	);

	executeStage executeStage_i (
		.Clk(Clk), .reset(reset), .exData(exData), .fwdA(fwdA), .fwdB(fwdB),
		.wbValue(wbValue), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.memData(memData)
	);

	writebackStage writebackStage_i (
		.Clk(Clk), .reset(reset), .memData(memData), .dataReadData(dataReadData),
		.wbWrite(wbWrite), .wbAddr(wbAddr), .wbValue(wbValue)
	);

	// Data port straight from EX/MEM
	assign dataAddr = memData.aluResult;
	assign dataWriteData = memData.storeData;
	assign dataWriteEnable = memData.memWrite;
	assign dataReadEnable = memData.memRead;

endmodule

/* hdl/mipsPkg.sv */
package mipsPkg;

	typedef logic [31:0] word;
	typedef logic [4:0] regAddr;

	localparam int numRegs = 32;
	localparam regAddr zeroReg = 5'd0;

	// Primary opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti  = 6'h0a;
	localparam logic [5:0] opAndi  = 6'h0c;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opXori  = 6'h0e;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// R-type funct codes
	localparam logic [5:0] fnSll  = 6'd0;
	localparam logic [5:0] fnAdd  = 6'd32;
	localparam logic [5:0] fnAddu = 6'd33;
	localparam logic [5:0] fnSub  = 6'd34;
	localparam logic [5:0] fnSubu = 6'd35;
	localparam logic [5:0] fnAnd  = 6'd36;
	localparam logic [5:0] fnOr   = 6'd37;
	localparam logic [5:0] fnXor  = 6'd38;
	localparam logic [5:0] fnNor  = 6'd39;
	localparam logic [5:0] fnSlt  = 6'd42;

	typedef enum logic [3:0] {
		aluAnd,
		aluOr,
		aluAdd,
		aluSub,
		aluXor,
		aluNor,
		aluSlt,
		aluSll,
		aluLui // Immediate into upper half
	} aluOp;

	typedef enum logic [1:0] {fromReg, fromMem, fromWb} fwdSel;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		aluOp alu;
		logic bSrcImm;   // B is the immediate
		logic aUseShamt; // A is rt, B is shamt
		logic branchEq;
		logic branchNe;
	} ctrlBits;

	typedef struct packed {
		ctrlBits ctrl;
		word rsVal;
		word rtVal;
		regAddr rs;
		regAddr rt;
		word imm;
		logic [4:0] shamt;
		regAddr dest;
		word pcPlus4;
	} idExData;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		word aluResult;
		word storeData;
		regAddr dest;
	} exMemData;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		word aluResult;
		word loadData;
		regAddr dest;
	} memWbData;

endpackage

/* hdl/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
	input logic Clk,
	input mipsPkg::regAddr rsAddr,
	input mipsPkg::regAddr rtAddr,
	output mipsPkg::word rsData,
	output mipsPkg::word rtData,
	input logic writeEnable,
	input mipsPkg::regAddr writeAddr,
	input mipsPkg::word writeData
);
	import mipsPkg::*;

	word regs [numRegs];

	// Write-through so WB and ID can share a cycle
	function automatic word readPort(regAddr addr);
		if (addr == zeroReg)
			return '0;
		else if (writeEnable && writeAddr == addr)
			return writeData;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge Clk) begin
		if (writeEnable && writeAddr != zeroReg)
			regs[writeAddr] <= writeData;
	end

	always_comb rsData = readPort(rsAddr);
	always_comb rtData = readPort(rtAddr);

endmodule

/* hdl/writebackStage.sv */
`timescale 1ns/1ps

module writebackStage (
	input logic Clk,
	input logic reset,
	input mipsPkg::exMemData memData,
	input mipsPkg::word dataReadData,
	output logic wbWrite,
	output mipsPkg::regAddr wbAddr,
	output mipsPkg::word wbValue
);
	import mipsPkg::*;

	memWbData wbData;

	always_ff @(posedge Clk) begin
		wbData.regWrite <= memData.regWrite;
		wbData.memToReg <= memData.memToReg;
		wbData.aluResult <= memData.aluResult;
		wbData.loadData <= dataReadData; // Sampled at end of MEM
		wbData.dest <= memData.dest;
		if (reset)
			wbData.regWrite <= 1'b0;
	end

	// Feeds register file and WB forwarding
	assign wbWrite = wbData.regWrite;
	assign wbAddr = wbData.dest;
	assign wbValue = wbData.memToReg ? wbData.loadData : wbData.aluResult;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the core testbench, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tbCore \
	-f files.f -o simCore \
	&& ./obj_dir/simCore | tee sim.log
grep -qx "Test OK" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* test/tbCore.sv */
`timescale 1ns/1ps

module tbCore;

	localparam int clkPeriod = 40;
	localparam int numTests = 5;
	localparam int cyclesPerTest = 90;
	localparam int watchdogCycles = numTests * cyclesPerTest;

	// MIPS encodings, taken from the ISA
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opXori = 6'h0e;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] fnSll = 6'd0;
	localparam logic [5:0] fnAdd = 6'd32;
	localparam logic [5:0] fnSub = 6'd34;
	localparam logic [5:0] fnAnd = 6'd36;
	localparam logic [5:0] fnOr = 6'd37;
	localparam logic [5:0] fnXor = 6'd38;
	localparam logic [5:0] fnNor = 6'd39;
	localparam logic [5:0] fnSlt = 6'd42;

	logic Clk;
	logic reset;
	logic [31:0] instrAddr;
	logic [31:0] instr;
	logic [31:0] dataAddr;
	logic [31:0] dataWriteData;
	logic dataWriteEnable;
	logic dataReadEnable;
	logic [31:0] dataReadData;

	logic [31:0] imem [1024];
	logic [31:0] dmem [256];
	int progLen;
	int errors;
	int checks;
	int readStrobes;

	mipsCore #(.resetVector(32'h0000_0000)) mipsCore_i (
		.Clk(Clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
		.dataAddr(dataAddr), .dataWriteData(dataWriteData),
		.dataWriteEnable(dataWriteEnable), .dataReadEnable(dataReadEnable),
		.dataReadData(dataReadData)
	);

	always #(clkPeriod / 2) Clk = ~Clk;

	assign instr = imem[instrAddr[11:2]];
	assign dataReadData = dmem[dataAddr[9:2]];

	always @(posedge Clk) begin
		if (dataWriteEnable)
			dmem[dataAddr[9:2]] <= dataWriteData; // Store lands at end of MEM
	end

	// One count per MEM cycle of a load
	always @(posedge Clk) begin
		if (dataReadEnable)
			readStrobes++;
	end

	function automatic logic [31:0] fillWord(logic [31:0] addr);
		return ~addr ^ {addr[15:0], addr[31:16]};
	endfunction

	task automatic emit(logic [31:0] w);
		imem[progLen[9:0]] = w;
		progLen++;
	endtask

	task automatic emitR(logic [5:0] funct, int rs, int rt, int rd, int shamt);
		emit({6'd0, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct});
	endtask

	task automatic emitI(logic [5:0] op, int rs, int rt, int imm);
		emit({op, rs[4:0], rt[4:0], imm[15:0]});
	endtask

	task automatic emitJ(int wordIndex);
		emit({opJ, wordIndex[25:0]});
	endtask

	task automatic loadConst(int rd, logic [31:0] v);
		emitI(opLui, 0, rd, int'(v[31:16]));
		emitI(opOri, rd, rd, int'(v[15:0]));
	endtask

	task automatic storeRegs(int first, int last, int base);
		for (int r = first; r <= last; r++)
			emitI(opSw, 0, r, base + 4 * (r - first));
	endtask

	task automatic writeWord(logic [31:0] addr, logic [31:0] v);
		dmem[addr[9:2]] = v;
	endtask

	// Core held in reset while both memories are rewritten
	task automatic startProgram();
		@(posedge Clk);
		#1 reset = 1'b1;
		for (int i = 0; i < 1024; i++)
			imem[i[9:0]] = 32'h0;
		for (int i = 0; i < 256; i++)
			dmem[i[7:0]] = fillWord(i << 2);
		progLen = 0;
		readStrobes = 0;
	endtask

	task automatic runProgram();
		emitJ(progLen); // Park on a jump to itself
		repeat (5) @(posedge Clk);
		#1 reset = 1'b0;
		repeat (80) @(posedge Clk);
		#1;
	endtask

	task automatic checkWord(string label, logic [31:0] addr, logic [31:0] want);
		logic [31:0] actual;
		actual = dmem[addr[9:2]];
		checks++;
		if (actual !== want) begin
			errors++;
			$display("[FAIL] %0t: %s word at 0x%h expected 0x%h, got 0x%h",
				$time, label, addr, want, actual);
		end
	endtask

	task automatic testRegisterAlu();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] want [8];
		a = $urandom;
		b = $urandom;
		startProgram();
		loadConst(1, a);
		loadConst(2, b);
		emitR(fnAdd, 1, 2, 3, 0);
		emitR(fnSub, 3, 2, 4, 0);
		emitR(fnAnd, 4, 3, 5, 0);
		emitR(fnOr, 5, 2, 6, 0);
		emitR(fnXor, 6, 1, 7, 0);
		emitR(fnNor, 7, 3, 8, 0);
		emitR(fnSlt, 8, 7, 9, 0);
		emitR(fnSll, 0, 8, 10, 7);
		storeRegs(3, 10, 'h100);
		runProgram();
		want[0] = a + b;
		want[1] = want[0] - b;
		want[2] = want[1] & want[0];
		want[3] = want[2] | b;
		want[4] = want[3] ^ a;
		want[5] = ~(want[4] | want[0]);
		want[6] = ($signed(want[5]) < $signed(want[4])) ? 32'd1 : 32'd0;
		want[7] = want[5] << 7;
		for (int k = 0; k < 8; k++)
			checkWord("register ALU", 32'h100 + 4 * k, want[k[2:0]]);
	endtask

	task automatic testImmediates();
		logic [31:0] a;
		logic [31:0] want [8];
		a = $urandom;
		startProgram();
		loadConst(1, a);
		emitI(opAddi, 1, 2, -1234);
		emitI(opSlti, 1, 3, -5);
		emitI(opSlti, 0, 4, -1); // Zero extension would give 1
		emitI(opAndi, 1, 5, 'hf0f0);
		emitI(opOri, 1, 6, 'h8001);
		emitI(opXori, 1, 7, 'hffff);
		emitI(opLui, 0, 8, 'h8765);
		emitI(opAddiu, 0, 9, -1);
		storeRegs(2, 9, 'h140);
		runProgram();
		want[0] = a - 32'd1234;
		want[1] = ($signed(a) < -5) ? 32'd1 : 32'd0;
		want[2] = 32'd0;
		want[3] = a & 32'h0000_f0f0;
		want[4] = a | 32'h0000_8001;
		want[5] = a ^ 32'h0000_ffff;
		want[6] = 32'h8765_0000;
		want[7] = 32'hffff_ffff;
		for (int k = 0; k < 8; k++)
			checkWord("immediate", 32'h140 + 4 * k, want[k[2:0]]);
	endtask

	task automatic testLoadUse();
		logic [31:0] pre;
		logic [31:0] c;
		pre = $urandom;
		c = $urandom;
		startProgram();
		writeWord(32'h180, pre);
		loadConst(1, c);
		emitI(opLw, 0, 2, 'h180);
		emitR(fnAdd, 2, 1, 3, 0); // Needs the load at once
		emitI(opSw, 0, 3, 'h184);
		emitI(opLw, 0, 4, 'h180);
		emitI(opSw, 0, 4, 'h188);
		runProgram();
		checkWord("load-use sum", 32'h184, pre + c);
		checkWord("load-use store", 32'h188, pre);
		checks++;
		if (readStrobes != 2) begin
			errors++;
			$display("[FAIL] %0t: load-use read strobe cycles expected 2, got %0d",
				$time, readStrobes);
		end
	endtask

	task automatic testBranches();
		startProgram();
		emitI(opAddi, 0, 1, 'h11);
		emitI(opAddi, 0, 3, 'h22);
		emitI(opAddi, 0, 4, 'h5a); // Marker
		emitI(opAddi, 0, 2, 'h11);
		emitI(opBeq, 1, 2, 2);
		emitI(opSw, 0, 4, 'h200);
		emitI(opSw, 0, 4, 'h204);
		emitI(opBne, 1, 3, 2);
		emitI(opSw, 0, 4, 'h208);
		emitI(opSw, 0, 4, 'h20c);
		emitI(opBeq, 1, 3, 1); // Falls through
		emitI(opSw, 0, 4, 'h210);
		emitI(opBne, 1, 2, 1);
		emitI(opSw, 0, 4, 'h214);
		runProgram();
		for (int k = 0; k < 4; k++)
			checkWord("taken branch", 32'h200 + 4 * k, fillWord(32'h200 + 4 * k));
		checkWord("BEQ not taken", 32'h210, 32'h5a);
		checkWord("BNE not taken", 32'h214, 32'h5a);
		checkWord("branch neighbour", 32'h218, fillWord(32'h218));
	endtask

	task automatic testJumpAndZero();
		startProgram();
		emitI(opAddi, 0, 4, 'h3c);
		emitJ(progLen + 2);
		emitI(opSw, 0, 4, 'h240); // Skipped by the jump
		emitI(opAddi, 0, 0, 'h77);
		emitI(opSw, 0, 0, 'h244);
		emitI(opSw, 0, 4, 'h248);
		runProgram();
		checkWord("jump skip", 32'h240, fillWord(32'h240));
		checkWord("r0 store", 32'h244, 32'h0);
		checkWord("after jump", 32'h248, 32'h3c);
	endtask

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog fired after %0d cycles, the run did not finish", watchdogCycles);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int unsigned seedDummy;
		Clk = 1'b0;
		reset = 1'b1;
		errors = 0;
		checks = 0;
		progLen = 0;
		readStrobes = 0;
		for (int i = 0; i < 1024; i++)
			imem[i[9:0]] = 32'h0;
		for (int i = 0; i < 256; i++)
			dmem[i[7:0]] = fillWord(i << 2);
		seedDummy = $urandom(32'h0f8cd2cc);
		testRegisterAlu();
		testImmediates();
		testLoadUse();
		testBranches();
		testJumpAndZero();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
